// ==== rtl/src_pkg.sv ====
`default_nettype none

package src_pkg;

  localparam int unsigned ADDR_W    = 32;                  // byte address
  localparam int unsigned STREAM_DW = 32;                  // one stream beat
  localparam int unsigned MEM_DW    = STREAM_DW + 32;      // extra word covers misalignment
  localparam int unsigned CNT_W     = 16;                  // beats per job
  localparam int unsigned OFS_W     = 2;                   // byte lane within a 32-bit word
  localparam int unsigned JOB_DEPTH = 2;                   // queued jobs
  localparam int unsigned OFS_DEPTH = 8;                   // max outstanding reads
  localparam int unsigned JOB_W     = 2 * ADDR_W + CNT_W;  // {len, stride, base}

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [MEM_DW-1:0]    mem_data_t;
  typedef logic [STREAM_DW-1:0] stream_data_t;
  typedef logic [CNT_W-1:0]     cnt_t;
  typedef logic [OFS_W-1:0]     ofs_t;

  typedef enum logic [1:0] {
    SRC_IDLE,     // no active job
    SRC_WORKING,  // requests still being issued
    SRC_DRAIN     // all granted, waiting for beats
  } src_state_e;

endpackage

`default_nettype wire

// ==== rtl/src_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module src_fifo #(
  parameter int unsigned WIDTH = 8,  // entry width
  parameter int unsigned DEPTH = 2   // number of entries
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             clear_i,       // flush all entries
  input  wire logic             push_valid_i,
  input  wire logic [WIDTH-1:0] push_data_i,
  input  wire logic             pop_ready_i,
  output logic                  push_ready_o,  // low when full
  output logic                  pop_valid_o,   // high when not empty
  output logic      [WIDTH-1:0] pop_data_o
);

  logic [WIDTH-1:0]           mem_q [DEPTH];  // ring storage
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] cnt_q;          // occupancy
  logic                       push;
  logic                       pop;

  assign push_ready_o = (cnt_q != ($clog2(DEPTH+1))'(DEPTH));
  assign pop_valid_o  = (cnt_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];      // head, valid only with pop_valid_o

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end  // push and pop together keep the count
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/src_job_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface src_job_if import src_pkg::*; ();

  logic  start;       // one-cycle pulse, fields below valid in that cycle
  addr_t base;        // first byte address
  addr_t stride;      // byte step between beats
  cnt_t  len;         // beats in the job
  logic  issue_done;  // level, all requests of the job granted

  modport ctrl (
    output start, base, stride, len,
    input  issue_done
  );

  modport issue (
    input  start, base, stride, len,
    output issue_done
  );

endinterface

`default_nettype wire

// ==== rtl/src_req_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

module src_req_issue
  import src_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic clear_i,
  src_job_if.issue  job,
  input  wire logic mem_gnt_i,
  input  wire logic stream_ready_i,  // back-pressure also stalls requests
  input  wire logic ofs_ready_i,     // room left in the offset queue
  output logic      mem_req_o,
  output addr_t     mem_addr_o,
  output logic      ofs_valid_o,
  output ofs_t      ofs_o
);

  addr_t addr_q;    // current byte address
  addr_t stride_q;  // latched at start
  cnt_t  len_q;     // latched at start
  cnt_t  cnt_q;     // granted requests so far
  logic  busy_q;    // requests still to issue
  logic  gnt;

  assign mem_req_o  = busy_q & stream_ready_i & ofs_ready_i;
  assign mem_addr_o = {addr_q[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};  // word aligned
  assign gnt        = mem_req_o & mem_gnt_i;

  // byte offset travels to the aligner with each granted read
  assign ofs_valid_o = gnt;
  assign ofs_o       = addr_q[OFS_W-1:0];

  assign job.issue_done = ~busy_q;  // stays high until the next start

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      addr_q <= '0;
    end else if (clear_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (job.start) begin
      addr_q <= job.base;
      cnt_q  <= '0;
      busy_q <= (job.len != '0);  // empty job is done at once
    end else if (gnt) begin
      addr_q <= addr_q + stride_q;  // linear walk
      cnt_q  <= cnt_q + 1'b1;
      if (cnt_q + 1'b1 == len_q) begin
        busy_q <= 1'b0;             // last request granted
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (job.start) begin
      stride_q <= job.stride;
      len_q    <= job.len;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/src_resp_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module src_resp_align
  import src_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      clear_i,
  input  wire mem_data_t mem_rdata_i,
  input  wire logic      mem_rvalid_i,
  input  wire logic      stream_ready_i,
  input  wire logic      ofs_valid_i,    // one push per granted read
  input  wire ofs_t      ofs_i,
  output logic           ofs_ready_o,
  output logic           mem_rready_o,
  output logic           stream_valid_o,
  output stream_data_t   stream_data_o,
  output logic           beat_o          // pulse per accepted beat
);

  mem_data_t hold_q;        // word parked during a stall
  logic      hold_valid_q;
  logic      hold_load;
  logic      resp_fire;
  logic      ofs_avail;     // a read is outstanding
  ofs_t      ofs_head;      // offset of the oldest read
  mem_data_t word;
  mem_data_t word_shifted;

  src_fifo #(
    .WIDTH ( OFS_W     ),
    .DEPTH ( OFS_DEPTH )
  ) i_ofs_fifo (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .clear_i      ( clear_i     ),
    .push_valid_i ( ofs_valid_i ),
    .push_data_i  ( ofs_i       ),
    .pop_ready_i  ( beat_o      ),  // offset retires with its beat
    .push_ready_o ( ofs_ready_o ),
    .pop_valid_o  ( ofs_avail   ),
    .pop_data_o   ( ofs_head    )
  );

  // accept while the stream moves or the holding register is free
  assign mem_rready_o = stream_ready_i | ~hold_valid_q;
  assign resp_fire    = mem_rvalid_i & mem_rready_o;

  // held word is older than the live one
  assign word          = hold_valid_q ? hold_q : mem_rdata_i;
  assign word_shifted  = word >> {ofs_head, 3'b000};  // byte offset to bits
  assign stream_data_o = word_shifted[STREAM_DW-1:0];

  // responses with no offset left are stale after a clear and get dropped
  assign stream_valid_o = (hold_valid_q | mem_rvalid_i) & ofs_avail;
  assign beat_o         = stream_valid_o & stream_ready_i;

  // live word parks if it cannot go out this cycle
  assign hold_load = resp_fire & ofs_avail & (hold_valid_q | ~stream_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else begin
      hold_valid_q <= hold_load | (hold_valid_q & ~stream_ready_i);  // refill or keep
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_load) begin
      hold_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/src_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module src_ctrl
  import src_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  clear_i,
  input  wire logic  job_valid_i,
  input  wire addr_t job_base_i,
  input  wire addr_t job_stride_i,
  input  wire cnt_t  job_len_i,
  input  wire logic  beat_i,      // one per accepted stream beat
  output logic       job_ready_o,
  output logic       done_o,      // pulse after the last beat
  src_job_if.ctrl    job
);

  src_state_e       state_q;
  src_state_e       state_d;
  logic [JOB_W-1:0] job_push_data;
  logic [JOB_W-1:0] job_pop_data;
  logic             job_pending;  // job waiting at queue head
  logic             start;
  cnt_t             len_q;        // beats of the active job
  cnt_t             beat_cnt_q;

  assign job_push_data = {job_len_i, job_stride_i, job_base_i};

  src_fifo #(
    .WIDTH ( JOB_W     ),
    .DEPTH ( JOB_DEPTH )
  ) i_job_fifo (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( job_valid_i   ),
    .push_data_i  ( job_push_data ),
    .pop_ready_i  ( start         ),  // head leaves the queue as it starts
    .push_ready_o ( job_ready_o   ),
    .pop_valid_o  ( job_pending   ),
    .pop_data_o   ( job_pop_data  )
  );

  assign job.start  = start;
  assign job.base   = job_pop_data[ADDR_W-1:0];
  assign job.stride = job_pop_data[2*ADDR_W-1:ADDR_W];
  assign job.len    = job_pop_data[JOB_W-1:2*ADDR_W];

  always_comb begin
    state_d = state_q;
    start   = 1'b0;
    done_o  = 1'b0;
    case (state_q)
      SRC_IDLE: begin
        if (job_pending) begin
          start   = 1'b1;
          state_d = SRC_WORKING;
        end
      end
      SRC_WORKING: begin
        if (job.issue_done) begin
          state_d = SRC_DRAIN;  // only beats left
        end
      end
      SRC_DRAIN: begin
        if (job.issue_done && (beat_cnt_q == len_q)) begin
          done_o  = 1'b1;
          start   = job_pending;  // chain the next job, no idle gap
          state_d = job_pending ? SRC_WORKING : SRC_IDLE;
        end
      end
      default: state_d = SRC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= SRC_IDLE;
      len_q      <= '0;
      beat_cnt_q <= '0;
    end else if (clear_i) begin
      state_q    <= SRC_IDLE;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (start) begin
        len_q      <= job.len;
        beat_cnt_q <= '0;  // previous job fully drained by now
      end else if (beat_i) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/src_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module src_top
  import src_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      clear_i,
  // job input
  input  wire logic      job_valid_i,
  output logic           job_ready_o,
  input  wire addr_t     job_base_i,
  input  wire addr_t     job_stride_i,
  input  wire cnt_t      job_len_i,
  output logic           done_o,
  // memory read port
  output logic           mem_req_o,
  input  wire logic      mem_gnt_i,
  output addr_t          mem_addr_o,
  input  wire mem_data_t mem_rdata_i,
  input  wire logic      mem_rvalid_i,
  output logic           mem_rready_o,
  // output stream
  output logic           stream_valid_o,
  input  wire logic      stream_ready_i,
  output stream_data_t   stream_data_o
);

  logic ofs_valid;  // granted read offset push
  ofs_t ofs;
  logic ofs_ready;
  logic beat;

  src_job_if job_bus ();

  src_ctrl i_ctrl (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .job_valid_i  ( job_valid_i  ),
    .job_base_i   ( job_base_i   ),
    .job_stride_i ( job_stride_i ),
    .job_len_i    ( job_len_i    ),
    .beat_i       ( beat         ),
    .job_ready_o  ( job_ready_o  ),
    .done_o       ( done_o       ),
    .job          ( job_bus.ctrl )
  );

  src_req_issue i_req_issue (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .job            ( job_bus.issue  ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .stream_ready_i ( stream_ready_i ),
    .ofs_ready_i    ( ofs_ready      ),
    .mem_req_o      ( mem_req_o      ),
    .mem_addr_o     ( mem_addr_o     ),
    .ofs_valid_o    ( ofs_valid      ),
    .ofs_o          ( ofs            )
  );

  src_resp_align i_resp_align (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .mem_rdata_i    ( mem_rdata_i    ),
    .mem_rvalid_i   ( mem_rvalid_i   ),
    .stream_ready_i ( stream_ready_i ),
    .ofs_valid_i    ( ofs_valid      ),
    .ofs_i          ( ofs            ),
    .ofs_ready_o    ( ofs_ready      ),
    .mem_rready_o   ( mem_rready_o   ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  ),
    .beat_o         ( beat           )
  );

endmodule

`default_nettype wire

// ==== verif/tb_src_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_src_top import src_pkg::*; ();

  localparam int TIMEOUT = 5000;  // cycles allowed per wait

  logic         clk_i;
  logic         rst_ni;
  logic         clear_i;
  logic         job_valid_i;
  logic         job_ready_o;
  addr_t        job_base_i;
  addr_t        job_stride_i;
  cnt_t         job_len_i;
  logic         done_o;
  logic         mem_req_o;
  logic         mem_gnt_i;
  addr_t        mem_addr_o;
  mem_data_t    mem_rdata_i;
  logic         mem_rvalid_i;
  logic         mem_rready_o;
  logic         stream_valid_o;
  logic         stream_ready_i;
  stream_data_t stream_data_o;

  integer       seed = 32'h5ab2;
  logic         rand_on = 1'b0;  // random stalls and grants
  int           lat_next = 1;    // read latency for the next grant
  int           errors = 0;
  int           tests = 0;
  int           failed = 0;
  int           done_cnt = 0;
  int           beat_cnt = 0;    // accepted stream beats
  int           cyc = 0;
  stream_data_t exp_q [$];       // expected beats, oldest first
  addr_t        rd_addr [$];     // granted reads not yet returned
  int           rd_due [$];      // earliest return cycle per read

  src_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;  // 40 ns period
  end

  // byte at any address, mixes all address bits
  function automatic logic [7:0] byte_at(addr_t a);
    logic [31:0] h;
    h = a * 32'h9e3779b1;
    return h[31:24] ^ h[7:0];
  endfunction

  function automatic stream_data_t beat_at(addr_t a);
    return {byte_at(a + 3), byte_at(a + 2), byte_at(a + 1), byte_at(a)};  // little endian
  endfunction

  function automatic mem_data_t word_at(addr_t a);
    mem_data_t w;
    int        i;
    for (i = 0; i < 8; i++) begin
      w[8*i +: 8] = byte_at(a + i);
    end
    return w;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s, stopped at cycle %0d", why, cyc);
    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    $display("Test failed");
    $finish;
  endtask

  always @(posedge clk_i) begin : drive_random
    int r;
    r = $random(seed);
    stream_ready_i <= rand_on ? (r[0] | r[1]) : 1'b1;  // about 3 in 4 when random
    mem_gnt_i      <= rand_on ? (r[2] | r[3]) : 1'b1;
    lat_next       <= $unsigned($random(seed)) % 6 + 1;
  end

  // in-order read memory, 1 to 6 cycles latency
  always @(posedge clk_i) begin : mem_model
    cyc++;
    if (clear_i) begin
      rd_addr.delete();  // reads in flight die with the clear
      rd_due.delete();
      mem_rvalid_i <= 1'b0;
    end else begin
      if (mem_rvalid_i && mem_rready_o) begin
        void'(rd_addr.pop_front());
        void'(rd_due.pop_front());
      end
      if (mem_req_o && mem_gnt_i) begin
        rd_addr.push_back(mem_addr_o);
        rd_due.push_back(cyc + lat_next);
      end
      if (rd_addr.size() > 0 && rd_due[0] <= cyc) begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= word_at(rd_addr[0]);
      end else begin
        mem_rvalid_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin : scoreboard
    if (rst_ni && stream_valid_o && stream_ready_i) begin
      beat_cnt <= beat_cnt + 1;
      if (exp_q.size() == 0) begin
        $display("stream beat %h arrived while none was expected", stream_data_o);
        errors++;
      end else begin
        check_val("stream_data_o", stream_data_o, exp_q.pop_front());
      end
    end
    if (done_o) done_cnt <= done_cnt + 1;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      stream_valid_o && !stream_ready_i && !clear_i |=> stream_valid_o && $stable(stream_data_o))
    else begin
      $display("stream beat changed or vanished while stalled");
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) mem_req_o |-> stream_ready_i)
    else begin
      $display("memory request raised while the stream was stalled");
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) done_o |=> !done_o)
    else begin
      $display("done_o stayed high for more than one cycle");
      errors++;
    end

  task automatic push_job(input addr_t base, input addr_t stride, input cnt_t len);
    int k;
    int t;
    for (k = 0; k < len; k++) begin
      exp_q.push_back(beat_at(base + k * stride));
    end
    job_valid_i  <= 1'b1;
    job_base_i   <= base;
    job_stride_i <= stride;
    job_len_i    <= len;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!job_ready_o && t < TIMEOUT);
    if (!job_ready_o) abort_run("job was never accepted");
    else job_valid_i <= 1'b0;
  endtask

  // waits for the done or beat counter to reach n
  task automatic wait_for(input bit on_done, input int n);
    int t;
    t = 0;
    while ((on_done ? done_cnt : beat_cnt) < n && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    if ((on_done ? done_cnt : beat_cnt) < n) abort_run("streamer made no progress in time");
  endtask

  task automatic end_test(input string name, input int err_start, input int done_exp);
    repeat (4) @(posedge clk_i);  // catch a late done or stray beat
    check_val("done_o count", done_cnt, done_exp);
    if (exp_q.size() != 0) begin
      $display("%0d expected beats never arrived", exp_q.size());
      errors++;
    end
    tests++;
    if (errors != err_start) failed++;
    $display("test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "bad");
  endtask

  initial begin
    int e0;
    int o;
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    job_valid_i    = 1'b0;
    job_base_i     = '0;
    job_stride_i   = '0;
    job_len_i      = '0;
    mem_gnt_i      = 1'b0;
    mem_rdata_i    = '0;
    mem_rvalid_i   = 1'b0;
    stream_ready_i = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    e0 = errors;  // idle outputs after reset
    check_val("mem_req_o", mem_req_o, 0);
    check_val("stream_valid_o", stream_valid_o, 0);
    check_val("done_o", done_o, 0);
    check_val("job_ready_o", job_ready_o, 1);
    end_test("reset state", e0, 0);

    e0 = errors;
    push_job(32'h100, 4, 16);
    wait_for(1'b1, 1);
    end_test("aligned job", e0, 1);

    e0 = errors;
    for (o = 1; o <= 3; o++) begin
      push_job(32'h200 + o * 32'h40 + o, 5, 8);  // base offsets 1, 2, 3
      wait_for(1'b1, 1 + o);
    end
    end_test("misaligned jobs", e0, 4);

    e0 = errors;
    rand_on <= 1'b1;
    push_job(32'h1003, 7, 40);
    push_job(32'h2002, 12, 24);
    wait_for(1'b1, 6);
    end_test("back-pressure", e0, 6);

    e0 = errors;
    push_job(32'h3001, 5, 12);
    push_job(32'h3100, 4, 12);
    push_job(32'h3203, 9, 12);
    @(posedge clk_i);
    check_val("job_ready_o", job_ready_o, 0);  // two jobs queued behind the active one
    wait_for(1'b1, 9);
    end_test("job queue", e0, 9);

    e0 = errors;
    push_job(32'h4002, 6, 40);
    wait_for(1'b0, beat_cnt + 5);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(posedge clk_i);
    check_val("stream_valid_o", stream_valid_o, 0);
    check_val("mem_req_o", mem_req_o, 0);
    exp_q.delete();  // rest of the cleared job never comes
    push_job(32'h5001, 3, 10);
    wait_for(1'b1, 10);
    end_test("clear", e0, 10);

    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/src_pkg.sv
rtl/src_fifo.sv
rtl/src_job_if.sv
rtl/src_req_issue.sv
rtl/src_resp_align.sv
rtl/src_ctrl.sv
rtl/src_top.sv
verif/tb_src_top.sv

// ==== Bender.yml ====
package:
  name: src_streamer

sources:
  - files:
      - rtl/src_pkg.sv
      - rtl/src_fifo.sv
      - rtl/src_job_if.sv
      - rtl/src_req_issue.sv
      - rtl/src_resp_align.sv
      - rtl/src_ctrl.sv
      - rtl/src_top.sv
  - target: test
    files:
      - verif/tb_src_top.sv
